// ==== verilog/mem_tile_pkg.sv ====
// Word widths, vector typedefs and request structs for the memory tile.
package mem_tile_pkg;

    // Bank word and config word widths.
    localparam int BANK_DATA_WIDTH = 64;
    localparam int CONFIG_DATA_WIDTH = 32;

    // Byte offset bits within a bank word.
    localparam int ADDR_OFFSET = 3;

    // Field widths of the address fields.
    localparam int BANK_ADDR_WIDTH_MAX = 16;
    localparam int SRAM_ADDR_WIDTH_MAX = BANK_ADDR_WIDTH_MAX - ADDR_OFFSET;

    // Data and config words.
    typedef logic [BANK_DATA_WIDTH-1:0] word_t;
    typedef logic [CONFIG_DATA_WIDTH-1:0] cfg_word_t;

    // Byte address inside a bank, and word index into a macro.
    typedef logic [BANK_ADDR_WIDTH_MAX-1:0] addr_t;
    typedef logic [SRAM_ADDR_WIDTH_MAX-1:0] sram_addr_t;

    // Data request to one bank.
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t data;
        word_t bit_sel;
    } bank_req_t;

    // Config request to one bank.
    typedef struct packed {
        logic      en;
        logic      wr;
        logic      rd;
        addr_t     addr;
        cfg_word_t wr_data;
    } cfg_req_t;

    // Controller to macro.
    typedef struct packed {
        logic       cen;
        logic       wen;
        sram_addr_t addr;
        word_t      data;
        word_t      bit_sel;
    } sram_req_t;

endpackage

// ==== verilog/sram_macro.sv ====
// Behavioural single-port SRAM with bit-masked write and registered read.
module sram_macro #(
    parameter int BANK_ADDR_WIDTH = 12
) (
    input  logic                    clk,
    input  mem_tile_pkg::sram_req_t sram_req,
    output mem_tile_pkg::word_t     rdata
);

    import mem_tile_pkg::*;

    localparam int WORD_ADDR_WIDTH = BANK_ADDR_WIDTH - ADDR_OFFSET;
    localparam int DEPTH = 2 ** WORD_ADDR_WIDTH;

    // Storage array.
    word_t mem [DEPTH];

    // Word index within depth.
    logic [WORD_ADDR_WIDTH-1:0] index;

    assign index = sram_req.addr[WORD_ADDR_WIDTH-1:0];

    // Write only the selected bits.
    always_ff @(posedge clk) begin
        if (sram_req.cen && sram_req.wen) begin
            mem[index] <= (mem[index] & ~sram_req.bit_sel)
                        | (sram_req.data & sram_req.bit_sel);
        end
    end

    // One-cycle read.
    // Output holds between reads.
    always_ff @(posedge clk) begin
        if (sram_req.cen && !sram_req.wen) begin
            rdata <= mem[index];
        end
    end

    // Upper index bits beyond the depth stay clear.
    a_addr_in_depth: assert property (
        @(posedge clk)
        sram_req.cen |-> (32'(sram_req.addr) < DEPTH)
    ) else $error("sram address %0h beyond depth %0d", sram_req.addr, DEPTH);

endmodule

// ==== verilog/sram_controller.sv ====
// Per-bank SRAM controller: request mux onto the macro and read data hold.
module sram_controller #(
    parameter int BANK_ADDR_WIDTH = 12
) (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_tile_pkg::bank_req_t bank_req,
    input  mem_tile_pkg::cfg_req_t  cfg_req,
    output mem_tile_pkg::word_t     data_out,
    output mem_tile_pkg::cfg_word_t config_rd_data,
    output mem_tile_pkg::sram_req_t sram_req,
    input  mem_tile_pkg::word_t     rdata
);

    import mem_tile_pkg::*;

    // Used word-index bits per bank.
    localparam int WORD_ADDR_WIDTH = BANK_ADDR_WIDTH - ADDR_OFFSET;
    localparam int HIGH_WIDTH = BANK_DATA_WIDTH - CONFIG_DATA_WIDTH;

    // Config half select, byte address bit 2.
    logic cfg_high;
    logic cfg_write;
    logic cfg_read;
    // Read issued to the macro this cycle.
    logic read_req;
    // Read completed at the last edge.
    logic read_valid;
    // Word from the last completed read.
    word_t held_word;
    word_t cfg_data;
    word_t cfg_mask;

    assign cfg_high = cfg_req.addr[ADDR_OFFSET-1];
    assign cfg_write = cfg_req.en && cfg_req.wr;
    assign cfg_read = cfg_req.en && cfg_req.rd;

    // Half-word data and mask for a config write.
    always_comb begin
        if (cfg_high) begin
            cfg_data = {cfg_req.wr_data[HIGH_WIDTH-1:0], {CONFIG_DATA_WIDTH{1'b0}}};
            cfg_mask = {{HIGH_WIDTH{1'b1}}, {CONFIG_DATA_WIDTH{1'b0}}};
        end else begin
            cfg_data = {{HIGH_WIDTH{1'b0}}, cfg_req.wr_data};
            cfg_mask = {{HIGH_WIDTH{1'b0}}, {CONFIG_DATA_WIDTH{1'b1}}};
        end
    end

    // Macro request.
    // Config takes priority over the data port.
    always_comb begin
        if (cfg_write) begin
            sram_req.cen = 1'b1;
            sram_req.wen = 1'b1;
            sram_req.addr = sram_addr_t'(cfg_req.addr[ADDR_OFFSET +: WORD_ADDR_WIDTH]);
            sram_req.data = cfg_data;
            sram_req.bit_sel = cfg_mask;
            read_req = 1'b0;
        end else if (cfg_read) begin
            sram_req.cen = 1'b1;
            sram_req.wen = 1'b0;
            sram_req.addr = sram_addr_t'(cfg_req.addr[ADDR_OFFSET +: WORD_ADDR_WIDTH]);
            sram_req.data = '0;
            sram_req.bit_sel = '0;
            read_req = 1'b1;
        end else begin
            sram_req.cen = bank_req.ren || bank_req.wen;
            sram_req.wen = bank_req.wen;
            sram_req.addr = sram_addr_t'(bank_req.addr[ADDR_OFFSET +: WORD_ADDR_WIDTH]);
            sram_req.data = bank_req.data;
            sram_req.bit_sel = bank_req.bit_sel;
            read_req = bank_req.ren;
        end
    end

    // Read valid flag and held word.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            read_valid <= 1'b0;
            held_word <= '0;
        end else begin
            read_valid <= read_req;
            held_word <= data_out;
        end
    end

    // Fresh macro data right after a read, held word otherwise.
    assign data_out = read_valid ? rdata : held_word;

    // Config read returns the chosen half.
    // Zero without a config read.
    always_comb begin
        if (!cfg_read) begin
            config_rd_data = '0;
        end else if (cfg_high) begin
            config_rd_data = data_out[BANK_DATA_WIDTH-1 -: CONFIG_DATA_WIDTH];
        end else begin
            config_rd_data = data_out[0 +: CONFIG_DATA_WIDTH];
        end
    end

    // One config operation at a time.
    a_cfg_wr_rd_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(cfg_req.en && cfg_req.wr && cfg_req.rd)
    ) else $error("config write and read asserted together");

    // Two config halves must cover the bank word.
    if (2 * CONFIG_DATA_WIDTH < BANK_DATA_WIDTH) begin : g_width_check
        $error("config data width below half of bank data width");
    end

endmodule

// ==== verilog/bank_select.sv ====
// Bank selector with bank decode, strobe gating and read data combine.
module bank_select #(
    parameter int BANK_ADDR_WIDTH = 12
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ren,
    input  logic                    wen,
    input  logic [BANK_ADDR_WIDTH:0] addr,
    input  mem_tile_pkg::word_t     data_in,
    input  mem_tile_pkg::word_t     data_in_bit_sel,
    output mem_tile_pkg::word_t     data_out,
    input  logic                    config_en,
    input  logic                    config_wr,
    input  logic                    config_rd,
    input  logic [BANK_ADDR_WIDTH:0] config_addr,
    input  mem_tile_pkg::cfg_word_t config_wr_data,
    output mem_tile_pkg::cfg_word_t config_rd_data,
    output mem_tile_pkg::bank_req_t bank_req [2],
    output mem_tile_pkg::cfg_req_t  cfg_req [2],
    input  mem_tile_pkg::word_t     bank_data_out [2],
    input  mem_tile_pkg::cfg_word_t bank_config_rd_data [2]
);

    import mem_tile_pkg::*;

    // Top address bit picks the bank.
    logic data_bank;
    logic cfg_bank;
    // Bank that served the last read.
    logic last_bank;
    logic last_bank_next;
    // Data read that a config write in the same bank does not block.
    logic data_read;

    assign data_bank = addr[BANK_ADDR_WIDTH];
    assign cfg_bank = config_addr[BANK_ADDR_WIDTH];
    assign data_read = ren && !(config_en && config_wr && cfg_bank == data_bank);

    // Per-bank requests.
    // Strobes only reach the addressed bank.
    for (genvar i = 0; i < 2; i++) begin : g_req
        assign bank_req[i].ren = ren && (data_bank == 1'(i));
        assign bank_req[i].wen = wen && (data_bank == 1'(i));
        assign bank_req[i].addr = addr_t'(addr[BANK_ADDR_WIDTH-1:0]);
        assign bank_req[i].data = data_in;
        assign bank_req[i].bit_sel = data_in_bit_sel;

        assign cfg_req[i].en = config_en && (cfg_bank == 1'(i));
        assign cfg_req[i].wr = config_wr;
        assign cfg_req[i].rd = config_rd;
        assign cfg_req[i].addr = addr_t'(config_addr[BANK_ADDR_WIDTH-1:0]);
        assign cfg_req[i].wr_data = config_wr_data;
    end

    // Track the bank of the newest read.
    // Data port read first, then config read.
    always_comb begin
        if (data_read) begin
            last_bank_next = data_bank;
        end else if (config_en && config_rd) begin
            last_bank_next = cfg_bank;
        end else begin
            last_bank_next = last_bank;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_bank <= 1'b0;
        end else begin
            last_bank <= last_bank_next;
        end
    end

    // Tile data follows the last read bank.
    assign data_out = bank_data_out[last_bank];

    // Idle banks return zero config data.
    assign config_rd_data = bank_config_rd_data[0] | bank_config_rd_data[1];

    // Data port never reads and writes together.
    a_ren_wen_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(ren && wen)
    ) else $error("data port ren and wen asserted together");

endmodule

// ==== verilog/mem_tile.sv ====
// Two-bank memory tile top: bank selector, two controllers, two SRAM macros.
module mem_tile #(
    parameter int BANK_ADDR_WIDTH = 12
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ren,
    input  logic                    wen,
    input  logic [BANK_ADDR_WIDTH:0] addr,
    input  mem_tile_pkg::word_t     data_in,
    input  mem_tile_pkg::word_t     data_in_bit_sel,
    output mem_tile_pkg::word_t     data_out,
    input  logic                    config_en,
    input  logic                    config_wr,
    input  logic                    config_rd,
    input  logic [BANK_ADDR_WIDTH:0] config_addr,
    input  mem_tile_pkg::cfg_word_t config_wr_data,
    output mem_tile_pkg::cfg_word_t config_rd_data
);

    import mem_tile_pkg::*;

    // Selector to bank paths.
    bank_req_t bank_req [2];
    cfg_req_t  cfg_req [2];
    // Bank paths back to selector.
    word_t     bank_data_out [2];
    cfg_word_t bank_config_rd_data [2];
    // Controller to macro.
    sram_req_t sram_req [2];
    word_t     rdata [2];

    bank_select #(
        .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
    ) select (
        .clk                 (clk),
        .reset               (reset),
        .ren                 (ren),
        .wen                 (wen),
        .addr                (addr),
        .data_in             (data_in),
        .data_in_bit_sel     (data_in_bit_sel),
        .data_out            (data_out),
        .config_en           (config_en),
        .config_wr           (config_wr),
        .config_rd           (config_rd),
        .config_addr         (config_addr),
        .config_wr_data      (config_wr_data),
        .config_rd_data      (config_rd_data),
        .bank_req            (bank_req),
        .cfg_req             (cfg_req),
        .bank_data_out       (bank_data_out),
        .bank_config_rd_data (bank_config_rd_data)
    );

    // Bank 0 path.
    sram_controller #(
        .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
    ) bank0_controller (
        .clk            (clk),
        .reset          (reset),
        .bank_req       (bank_req[0]),
        .cfg_req        (cfg_req[0]),
        .data_out       (bank_data_out[0]),
        .config_rd_data (bank_config_rd_data[0]),
        .sram_req       (sram_req[0]),
        .rdata          (rdata[0])
    );

    sram_macro #(
        .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
    ) bank0_macro (
        .clk      (clk),
        .sram_req (sram_req[0]),
        .rdata    (rdata[0])
    );

    // Bank 1 path.
    sram_controller #(
        .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
    ) bank1_controller (
        .clk            (clk),
        .reset          (reset),
        .bank_req       (bank_req[1]),
        .cfg_req        (cfg_req[1]),
        .data_out       (bank_data_out[1]),
        .config_rd_data (bank_config_rd_data[1]),
        .sram_req       (sram_req[1]),
        .rdata          (rdata[1])
    );

    sram_macro #(
        .BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)
    ) bank1_macro (
        .clk      (clk),
        .sram_req (sram_req[1]),
        .rdata    (rdata[1])
    );

endmodule

// ==== tests/mem_tile_checker.sv ====
// Tile reference model with bank word arrays, last read word and output comparisons.
module mem_tile_checker #(
    parameter int BANK_ADDR_WIDTH = 12
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     ren,
    input  logic                     wen,
    input  logic [BANK_ADDR_WIDTH:0] addr,
    input  mem_tile_pkg::word_t      data_in,
    input  mem_tile_pkg::word_t      data_in_bit_sel,
    input  mem_tile_pkg::word_t      data_out,
    input  logic                     config_en,
    input  logic                     config_wr,
    input  logic                     config_rd,
    input  logic [BANK_ADDR_WIDTH:0] config_addr,
    input  mem_tile_pkg::cfg_word_t  config_wr_data,
    input  mem_tile_pkg::cfg_word_t  config_rd_data,
    output int                       pass_count,
    output int                       fail_count,
    output logic                     idle
);
    timeunit 1ns;
    timeprecision 1ps;

    import mem_tile_pkg::*;

    localparam int WORD_BITS = BANK_ADDR_WIDTH - ADDR_OFFSET;
    localparam int DEPTH = 2 ** WORD_BITS;

    // Model of both banks.
    word_t model_mem [2][DEPTH];
    // Word of the newest completed read.
    word_t last_word;
    // Config read presented in the previous cycle, and its address.
    logic prev_cfg_rd;
    logic [BANK_ADDR_WIDTH:0] prev_cfg_addr;
    // A read result still waiting for its check.
    logic pending = 1'b0;
    int passes = 0;
    int failures = 0;

    assign pass_count = passes;
    assign fail_count = failures;
    assign idle = !pending;

    function automatic word_t merge(input word_t old, input word_t fresh, input word_t mask);
        return (old & ~mask) | (fresh & mask);
    endfunction

    // Bit 2 of the byte address picks the upper half.
    function automatic cfg_word_t pick_half(input word_t w, input logic high);
        return high ? w[63:32] : w[31:0];
    endfunction

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            failures++;
            $display("[FAIL] %s expected %h got %h at %0t", name, expected, actual, $time);
        end else begin
            passes++;
        end
    endtask

    // Effect of the inputs at the coming rising edge.
    task automatic apply_inputs();
        logic cfg_bank;
        logic data_bank;
        logic cfg_busy;
        logic [WORD_BITS-1:0] cfg_idx;
        logic [WORD_BITS-1:0] data_idx;
        cfg_bank = config_addr[BANK_ADDR_WIDTH];
        data_bank = addr[BANK_ADDR_WIDTH];
        cfg_idx = config_addr[ADDR_OFFSET +: WORD_BITS];
        data_idx = addr[ADDR_OFFSET +: WORD_BITS];
        cfg_busy = config_en && (config_wr || config_rd);
        pending = 1'b0;
        if (config_en && config_wr) begin
            if (config_addr[2]) begin
                model_mem[cfg_bank][cfg_idx] = merge(model_mem[cfg_bank][cfg_idx],
                    {config_wr_data, 32'h0}, {32'hffffffff, 32'h0});
            end else begin
                model_mem[cfg_bank][cfg_idx] = merge(model_mem[cfg_bank][cfg_idx],
                    {32'h0, config_wr_data}, {32'h0, 32'hffffffff});
            end
        end else if (config_en && config_rd) begin
            last_word = model_mem[cfg_bank][cfg_idx];
            pending = 1'b1;
        end
        // Data port loses to a config op in the same bank.
        if (!(cfg_busy && cfg_bank == data_bank)) begin
            if (wen) begin
                model_mem[data_bank][data_idx] = merge(model_mem[data_bank][data_idx],
                    data_in, data_in_bit_sel);
            end else if (ren) begin
                last_word = model_mem[data_bank][data_idx];
                pending = 1'b1;
            end
        end
        prev_cfg_rd = config_en && config_rd;
        prev_cfg_addr = config_addr;
    endtask

    // Outputs are settled mid-cycle; inputs too.
    always @(negedge clk) begin
        if (reset) begin
            last_word = '0;
            prev_cfg_rd = 1'b0;
            pending = 1'b0;
        end else begin
            compare("data_out", last_word, data_out);
            if (!(config_en && config_rd)) begin
                compare("config_rd_data", '0, word_t'(config_rd_data));
            end else if (prev_cfg_rd && prev_cfg_addr == config_addr) begin
                compare("config_rd_data", word_t'(pick_half(last_word, config_addr[2])),
                    word_t'(config_rd_data));
            end
            apply_inputs();
        end
    end

endmodule

// ==== tests/mem_tile_tb.sv ====
// Testbench top with clock, reset, DUT, checker and random stimulus phases.
module mem_tile_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_tile_pkg::*;

    localparam int BANK_ADDR_WIDTH = 12;
    localparam int WORD_BITS = BANK_ADDR_WIDTH - ADDR_OFFSET;
    // Words per bank that the stimulus uses.
    localparam int WINDOW = 8;

    logic clk;
    logic reset;
    logic ren;
    logic wen;
    logic [BANK_ADDR_WIDTH:0] addr;
    word_t data_in;
    word_t data_in_bit_sel;
    word_t data_out;
    logic config_en;
    logic config_wr;
    logic config_rd;
    logic [BANK_ADDR_WIDTH:0] config_addr;
    cfg_word_t config_wr_data;
    cfg_word_t config_rd_data;
    int pass_count;
    int fail_count;
    logic idle;
    logic timed_out;
    integer seed = 24869;

    mem_tile #(.BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)) dut (.*);

    mem_tile_checker #(.BANK_ADDR_WIDTH(BANK_ADDR_WIDTH)) check (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // Bank bit, word index, random byte offset.
    function automatic logic [BANK_ADDR_WIDTH:0] make_addr(input logic bank, input int idx);
        int r;
        r = $random(seed);
        return {bank, idx[WORD_BITS-1:0], r[ADDR_OFFSET-1:0]};
    endfunction

    // Inputs change 2 ns after the edge.
    task automatic next_cycle();
        @(posedge clk);
        #2;
        ren = 1'b0;
        wen = 1'b0;
        config_en = 1'b0;
        config_wr = 1'b0;
        config_rd = 1'b0;
    endtask

    task automatic data_op(input logic write, input logic bank, input int idx, input word_t mask);
        next_cycle();
        ren = !write;
        wen = write;
        addr = make_addr(bank, idx);
        data_in = rand_word();
        data_in_bit_sel = mask;
    endtask

    // Config op held with one address.
    task automatic cfg_op(input logic write, input logic bank, input int idx, input int cycles);
        logic [BANK_ADDR_WIDTH:0] a;
        a = make_addr(bank, idx);
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            config_en = 1'b1;
            config_wr = write;
            config_rd = !write;
            config_addr = a;
            config_wr_data = $random(seed);
        end
    endtask

    task automatic report_phase(input string name);
        $display("%s done, failures so far %0d", name, fail_count);
    endtask

    task automatic run_phases();
        int r;
        repeat (4) next_cycle();
        report_phase("reset values");
        for (int i = 0; i < 2 * WINDOW; i++) begin
            data_op(1'b1, i[0], i >> 1, '1);
        end
        report_phase("window fill");
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            if (((r >> 8) & 3) == 0) begin
                data_op(1'b1, r[0], (r >> 4) & (WINDOW - 1), rand_word());
            end else if (((r >> 8) & 3) == 3) begin
                next_cycle();
            end else begin
                data_op(1'b0, r[0], (r >> 4) & (WINDOW - 1), '0);
            end
        end
        report_phase("masked data");
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            cfg_op(1'b1, r[0], (r >> 4) & (WINDOW - 1), 1);
            data_op(1'b0, r[0], (r >> 4) & (WINDOW - 1), '0);
        end
        report_phase("config write");
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            cfg_op(1'b0, r[0], (r >> 4) & (WINDOW - 1), 2);
            next_cycle();
        end
        report_phase("config read");
        // Config write and data write in one bank, same cycle.
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            next_cycle();
            config_en = 1'b1;
            config_wr = 1'b1;
            config_addr = make_addr(r[0], (r >> 4) & (WINDOW - 1));
            config_wr_data = $random(seed);
            wen = 1'b1;
            addr = make_addr(r[0], (r >> 8) & (WINDOW - 1));
            data_in = rand_word();
            data_in_bit_sel = rand_word();
            data_op(1'b0, r[0], (r >> 4) & (WINDOW - 1), '0);
            data_op(1'b0, r[0], (r >> 8) & (WINDOW - 1), '0);
        end
        report_phase("write collision");
    endtask

    // Last read must reach its check.
    task automatic wait_checker_idle();
        int count;
        count = 0;
        next_cycle();
        while (!idle && count < 20) begin
            @(posedge clk);
            count++;
        end
        if (!idle) begin
            timed_out = 1'b1;
            $display("timeout while the checker still waited for a read result");
        end
    endtask

    initial begin
        reset = 1'b1;
        ren = 1'b0;
        wen = 1'b0;
        addr = '0;
        data_in = '0;
        data_in_bit_sel = '0;
        config_en = 1'b0;
        config_wr = 1'b0;
        config_rd = 1'b0;
        config_addr = '0;
        config_wr_data = '0;
        timed_out = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        run_phases();
        wait_checker_idle();
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (!timed_out && fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/mem_tile_pkg.sv
verilog/sram_macro.sv
verilog/sram_controller.sv
verilog/bank_select.sv
verilog/mem_tile.sv
tests/mem_tile_checker.sv
tests/mem_tile_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory tile testbench with Verilator, run it, then search the log.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module mem_tile_tb \
    -f verilog.f -o mem_tile_sim > build.log 2>&1 &&
./obj_dir/mem_tile_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete"; exit 1; }
grep -q "TEST PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
